/* source/ws281x_pkg.sv */
`default_nettype none

package ws281x_pkg;

  // --------------------------------------
  // Bus widths
  // --------------------------------------

  // Word address on the register bus
  typedef logic [3:0]  reg_addr_t;
  // Bus data and byte enables
  typedef logic [31:0] reg_data_t;
  typedef logic [3:0]  reg_be_t;

  // One GRB pixel, sent MSB first
  typedef logic [23:0] pixel_t;
  localparam int PIXEL_BITS = $bits(pixel_t);

  // Bit timing in mclk cycles
  typedef logic [9:0]  bit_period_t;
  // Latch low time in mclk cycles
  typedef logic [15:0] rst_period_t;

  // --------------------------------------
  // Register map
  // --------------------------------------
  localparam reg_addr_t REG_ENB   = 4'd0;
  localparam reg_addr_t REG_RST   = 4'd1;
  localparam reg_addr_t REG_TIM   = 4'd2;
  localparam reg_addr_t REG_STS   = 4'd3;
  // Port p data at REG_DATA0 + p
  localparam reg_addr_t REG_DATA0 = 4'd4;

  // Serializer FSM
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_HIGH,
    ST_LOW,
    ST_LATCH
  } ser_state_t;

endpackage

`default_nettype wire

/* source/ws281x_fifo.sv */
`default_nettype none

module ws281x_fifo import ws281x_pkg::*; #(
  parameter int WIDTH = 24,
  parameter int DEPTH = 8
) (
  input  wire logic mclk,
  input  wire logic h_reset_n,
  input  wire logic wr_en,
  input  pixel_t    wr_data,
  input  wire logic rd_en,
  output pixel_t    rd_data,
  output logic      full,
  output logic      empty
);

  localparam int AW = $clog2(DEPTH);

  // Storage word must hold a whole pixel
  if (WIDTH != $bits(pixel_t)) begin : g_width_check
    $error("ws281x_fifo WIDTH must match pixel_t");
  end

  // Pixel storage
  logic [WIDTH-1:0] mem [DEPTH];

  // Extra MSB tells a full buffer from an empty one
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;

  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge mclk) begin
    if (wr_en)
      mem[wr_ptr[AW-1:0]] <= wr_data;
  end

  // Head word, visible one cycle after the first push
  assign rd_data = mem[rd_ptr[AW-1:0]];

  // Same slot, wrapped a different number of times
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign empty = (wr_ptr == rd_ptr);

  // Writer side must respect back-pressure
  a_no_push_full: assert property (
    @(posedge mclk) disable iff (!h_reset_n) !(wr_en && full)
  );

  // Serializer only pops a valid head
  a_no_pop_empty: assert property (
    @(posedge mclk) disable iff (!h_reset_n) !(rd_en && empty)
  );

endmodule

`default_nettype wire

/* source/ws281x_reg.sv */
`default_nettype none

module ws281x_reg import ws281x_pkg::*; #(
  parameter int NP         = 4,
  parameter int FIFO_DEPTH = 8
) (
  input  wire logic        mclk,
  input  wire logic        h_reset_n,

  // Register bus
  input  wire logic        reg_cs,
  input  wire logic        reg_wr,
  input  reg_addr_t        reg_addr,
  input  reg_data_t        reg_wdata,
  input  reg_be_t          reg_be,
  output reg_data_t        reg_rdata,
  output logic             reg_ack,

  // Shared timing configuration
  output rst_period_t      cfg_rst_period,
  output bit_period_t      cfg_bit_period,
  output bit_period_t      cfg_th0_period,
  output bit_period_t      cfg_th1_period,

  // Pixel path, one entry per port
  output logic [NP-1:0]    port_enb,
  input  wire logic [NP-1:0] port_rd,
  output pixel_t           port_data [NP],
  output logic [NP-1:0]    port_dval
);

  // --------------------------------------
  // Bus decode
  // --------------------------------------
  logic          bus_rd;
  logic          bus_wr;
  logic [NP-1:0] data_hit;
  logic          wr_block;
  logic          ack_set;
  logic          cfg_wr;

  // Timing register, three 10-bit fields
  logic [29:0]   cfg_tim;

  logic [NP-1:0] fifo_full;
  logic [NP-1:0] fifo_empty;
  logic [NP-1:0] fifo_wr;

  reg_data_t     sts;
  reg_data_t     rd_mux;

  assign bus_rd = reg_cs && !reg_wr;
  assign bus_wr = reg_cs && reg_wr;

  // Data write to a full FIFO stalls the bus
  assign wr_block = bus_wr && |(data_hit & fifo_full);

  // One ack per access, never back to back
  assign ack_set = reg_cs && !reg_ack && !wr_block;
  assign cfg_wr  = ack_set && reg_wr;

  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n)
      reg_ack <= 1'b0;
    else
      reg_ack <= ack_set;
  end

  // Read data travels with the ack
  always_ff @(posedge mclk) begin
    if (ack_set && bus_rd)
      reg_rdata <= rd_mux;
  end

  // --------------------------------------
  // Configuration registers
  // --------------------------------------
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      port_enb       <= '0;
      cfg_rst_period <= '0;
      cfg_tim        <= '0;
    end else if (cfg_wr) begin
      // Port enables, one bit per port in byte 0
      if (reg_addr == REG_ENB && reg_be[0])
        port_enb <= reg_wdata[NP-1:0];
      // Latch period
      if (reg_addr == REG_RST) begin
        if (reg_be[0])
          cfg_rst_period[7:0] <= reg_wdata[7:0];
        if (reg_be[1])
          cfg_rst_period[15:8] <= reg_wdata[15:8];
      end
      // Bit timing, top two bits not stored
      if (reg_addr == REG_TIM) begin
        if (reg_be[0])
          cfg_tim[7:0] <= reg_wdata[7:0];
        if (reg_be[1])
          cfg_tim[15:8] <= reg_wdata[15:8];
        if (reg_be[2])
          cfg_tim[23:16] <= reg_wdata[23:16];
        if (reg_be[3])
          cfg_tim[29:24] <= reg_wdata[29:24];
      end
    end
  end

  assign cfg_bit_period = cfg_tim[9:0];
  // High time for a 0-bit
  assign cfg_th0_period = cfg_tim[19:10];
  // High time for a 1-bit
  assign cfg_th1_period = cfg_tim[29:20];

  // --------------------------------------
  // Per-port pixel FIFOs
  // --------------------------------------
  for (genvar p = 0; p < NP; p++) begin : g_port
    assign data_hit[p] = (reg_addr == reg_addr_t'(REG_DATA0 + p));

    // Push lands in the ack cycle, master still holds the data
    assign fifo_wr[p] = reg_ack && bus_wr && data_hit[p];

    ws281x_fifo #(
      .WIDTH ($bits(pixel_t)),
      .DEPTH (FIFO_DEPTH)
    ) u_fifo (
      .mclk      (mclk),
      .h_reset_n (h_reset_n),
      .wr_en     (fifo_wr[p]),
      .wr_data   (reg_wdata[23:0]),
      .rd_en     (port_rd[p]),
      .rd_data   (port_data[p]),
      .full      (fifo_full[p]),
      .empty     (fifo_empty[p])
    );

    assign port_dval[p] = !fifo_empty[p];
  end

  // Status, one byte per port, absent ports read zero
  always_comb begin
    sts = '0;
    for (int p = 0; p < NP; p++) begin
      sts[8*p +: 8] = {6'd0, fifo_empty[p], fifo_full[p]};
    end
  end

  // --------------------------------------
  // Read multiplexer
  // --------------------------------------
  always_comb begin
    rd_mux = '0;
    case (reg_addr)
      REG_ENB: rd_mux = reg_data_t'(port_enb);
      REG_RST: rd_mux = reg_data_t'(cfg_rst_period);
      REG_TIM: rd_mux = reg_data_t'(cfg_tim);
      REG_STS: rd_mux = sts;
      default: begin
        // FIFO head of the addressed port
        for (int p = 0; p < NP; p++) begin
          if (data_hit[p])
            rd_mux = reg_data_t'(port_data[p]);
        end
      end
    endcase
  end

  // Master holds the access through the ack cycle so the push sees its data
  a_ack_held: assert property (
    @(posedge mclk) disable iff (!h_reset_n) reg_ack |-> reg_cs
  );

endmodule

`default_nettype wire

/* source/ws281x_serializer.sv */
`default_nettype none

module ws281x_serializer import ws281x_pkg::*; (
  input  wire logic  mclk,
  input  wire logic  h_reset_n,

  // Pixel handshake with the FIFO
  input  wire logic  port_enb,
  input  wire logic  port_dval,
  input  pixel_t     port_data,
  output logic       port_rd,

  // Shared timing
  input  rst_period_t cfg_rst_period,
  input  bit_period_t cfg_bit_period,
  input  bit_period_t cfg_th0_period,
  input  bit_period_t cfg_th1_period,

  output logic       led_dout
);

  ser_state_t  state;
  // Pixel being sent, MSB leads
  pixel_t      shift_reg;
  // Bits already finished in this pixel
  logic [4:0]  bit_cnt;
  // Shared by bit timing and latch timing
  rst_period_t cyc_cnt;
  rst_period_t cyc_nxt;

  bit_period_t th_cur;
  logic        high_done;
  logic        bit_done;
  logic        last_bit;
  logic        latch_done;
  logic        start;
  logic        chain;

  // --------------------------------------
  // Timing compares
  // --------------------------------------
  assign cyc_nxt = cyc_cnt + 1'b1;

  // High time follows the bit on the wire
  assign th_cur = shift_reg[PIXEL_BITS-1] ? cfg_th1_period : cfg_th0_period;

  assign high_done  = (cyc_nxt >= rst_period_t'(th_cur));
  assign bit_done   = (cyc_nxt >= rst_period_t'(cfg_bit_period));
  assign last_bit   = (bit_cnt == 5'(PIXEL_BITS - 1));
  assign latch_done = (cyc_nxt >= cfg_rst_period);

  // Fresh start needs the enable, a chained pixel does not
  assign start = (state == ST_IDLE) && port_enb && port_dval;
  assign chain = (state == ST_LOW) && bit_done && last_bit && port_dval;

  assign port_rd = start || chain;

  // --------------------------------------
  // FSM
  // --------------------------------------
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      state   <= ST_IDLE;
      bit_cnt <= '0;
      cyc_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state   <= ST_HIGH;
            bit_cnt <= '0;
            cyc_cnt <= '0;
          end
        end
        ST_HIGH: begin
          // Counter keeps running across the HIGH to LOW switch
          cyc_cnt <= cyc_nxt;
          if (high_done)
            state <= ST_LOW;
        end
        ST_LOW: begin
          if (bit_done) begin
            cyc_cnt <= '0;
            if (!last_bit) begin
              bit_cnt <= bit_cnt + 1'b1;
              state   <= ST_HIGH;
            end else if (chain) begin
              // Next pixel back to back
              bit_cnt <= '0;
              state   <= ST_HIGH;
            end else begin
              state <= ST_LATCH;
            end
          end else begin
            cyc_cnt <= cyc_nxt;
          end
        end
        ST_LATCH: begin
          // Line low for the reset period
          if (latch_done) begin
            cyc_cnt <= '0;
            state   <= ST_IDLE;
          end else begin
            cyc_cnt <= cyc_nxt;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Load on pop, shift at each bit boundary
  always_ff @(posedge mclk) begin
    if (port_rd)
      shift_reg <= port_data;
    else if (state == ST_LOW && bit_done)
      shift_reg <= {shift_reg[PIXEL_BITS-2:0], 1'b0};
  end

  assign led_dout = (state == ST_HIGH);

  // FIFO head stays valid until this port pops it
  a_dval_hold: assert property (
    @(posedge mclk) disable iff (!h_reset_n) port_dval && !port_rd |=> port_dval
  );

endmodule

`default_nettype wire

/* source/ws281x_top.sv */
`default_nettype none

module ws281x_top import ws281x_pkg::*; #(
  parameter int NP         = 4,
  parameter int FIFO_DEPTH = 8
) (
  input  wire logic     mclk,
  input  wire logic     h_reset_n,

  // Register bus
  input  wire logic     reg_cs,
  input  wire logic     reg_wr,
  input  reg_addr_t     reg_addr,
  input  reg_data_t     reg_wdata,
  input  reg_be_t       reg_be,
  output reg_data_t     reg_rdata,
  output logic          reg_ack,

  // One LED line per port
  output logic [NP-1:0] led_dout
);

  // Shared timing
  rst_period_t   cfg_rst_period;
  bit_period_t   cfg_bit_period;
  bit_period_t   cfg_th0_period;
  bit_period_t   cfg_th1_period;

  // Pixel path
  logic [NP-1:0] port_enb;
  logic [NP-1:0] port_rd;
  logic [NP-1:0] port_dval;
  pixel_t        port_data [NP];

  ws281x_reg #(
    .NP         (NP),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_reg (
    .mclk           (mclk),
    .h_reset_n      (h_reset_n),
    .reg_cs         (reg_cs),
    .reg_wr         (reg_wr),
    .reg_addr       (reg_addr),
    .reg_wdata      (reg_wdata),
    .reg_be         (reg_be),
    .reg_rdata      (reg_rdata),
    .reg_ack        (reg_ack),
    .cfg_rst_period (cfg_rst_period),
    .cfg_bit_period (cfg_bit_period),
    .cfg_th0_period (cfg_th0_period),
    .cfg_th1_period (cfg_th1_period),
    .port_enb       (port_enb),
    .port_rd        (port_rd),
    .port_data      (port_data),
    .port_dval      (port_dval)
  );

  // --------------------------------------
  // One serializer per port
  // --------------------------------------
  for (genvar p = 0; p < NP; p++) begin : g_ser
    ws281x_serializer u_ser (
      .mclk           (mclk),
      .h_reset_n      (h_reset_n),
      .port_enb       (port_enb[p]),
      .port_dval      (port_dval[p]),
      .port_data      (port_data[p]),
      .port_rd        (port_rd[p]),
      .cfg_rst_period (cfg_rst_period),
      .cfg_bit_period (cfg_bit_period),
      .cfg_th0_period (cfg_th0_period),
      .cfg_th1_period (cfg_th1_period),
      .led_dout       (led_dout[p])
    );
  end

endmodule

`default_nettype wire

/* test/ws281x_tb.sv */
`default_nettype none

module ws281x_tb import ws281x_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NP            = 4;
  localparam int FIFO_DEPTH    = 8;
  // Waveform timing in mclk cycles
  localparam int BIT_PER       = 20;
  localparam int TH0           = 6;
  localparam int TH1           = 13;
  localparam int RST_PER       = 60;
  // Wait limits in cycles
  localparam int ACK_TIMEOUT   = 20;
  localparam int START_TIMEOUT = 50;
  localparam int PIXEL_TIMEOUT = 24 * BIT_PER + RST_PER;
  // Stored bits of the config registers
  localparam reg_data_t TIM_MASK = 32'h3FFF_FFFF;
  localparam reg_data_t RST_MASK = 32'h0000_FFFF;

  logic          mclk;
  logic          h_reset_n;
  logic          reg_cs;
  logic          reg_wr;
  reg_addr_t     reg_addr;
  reg_data_t     reg_wdata;
  reg_be_t       reg_be;
  reg_data_t     reg_rdata;
  logic          reg_ack;
  logic [NP-1:0] led_dout;

  logic [15:0]   lfsr_state;
  logic          watch_idle;
  // Words pushed into port 0, in order
  pixel_t        port0_pix [FIFO_DEPTH];

  ws281x_top #(
    .NP         (NP),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) ws281x_top_i (
    .mclk      (mclk),
    .h_reset_n (h_reset_n),
    .reg_cs    (reg_cs),
    .reg_wr    (reg_wr),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_be    (reg_be),
    .reg_rdata (reg_rdata),
    .reg_ack   (reg_ack),
    .led_dout  (led_dout)
  );

  // 100 ns clock
  initial begin
    mclk = 1'b0;
    forever #50 mclk = ~mclk;
  end

  // --------------------------------------
  // Reporting
  // --------------------------------------
  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Error: %s expected 0x%08h actual 0x%08h", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "run aborted");
  endtask

  // Ports 2 and 3 never get data, lines must stay low
  always @(negedge mclk) begin
    if (watch_idle)
      check_equal("idle_ports", 32'd0, 32'(led_dout[3:2]));
  end

  // --------------------------------------
  // Stimulus helpers
  // --------------------------------------
  // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0])
      n = n ^ 16'hB400;
    return n;
  endfunction

  // One step per pixel bit
  task automatic next_pixel(output pixel_t px);
    px = '0;
    for (int b = 0; b < 24; b++) begin
      px = {px[22:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Old word with the enabled bytes replaced
  function automatic reg_data_t byte_merge(input reg_data_t old_val, input reg_data_t new_val,
                                           input reg_be_t be);
    reg_data_t res;
    res = old_val;
    for (int i = 0; i < 4; i++) begin
      if (be[i])
        res[8*i +: 8] = new_val[8*i +: 8];
    end
    return res;
  endfunction

  task automatic wait_ack(input string what, input int limit);
    int cycles;
    cycles = 0;
    @(negedge mclk);
    while (!reg_ack) begin
      cycles++;
      if (cycles >= limit)
        abort_run($sformatf("No bus acknowledge for the %s", what));
      else
        @(negedge mclk);
    end
  endtask

  task automatic bus_write(input reg_addr_t addr, input reg_data_t data, input reg_be_t be,
                           input int limit = ACK_TIMEOUT);
    reg_cs    = 1'b1;
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    reg_be    = be;
    wait_ack($sformatf("write to address %0d", addr), limit);
    // FIFO push lands at the end of the ack cycle
    @(negedge mclk);
    reg_cs = 1'b0;
    reg_wr = 1'b0;
  endtask

  task automatic bus_read(input reg_addr_t addr, output reg_data_t data);
    reg_cs   = 1'b1;
    reg_wr   = 1'b0;
    reg_addr = addr;
    reg_be   = 4'hF;
    wait_ack($sformatf("read of address %0d", addr), ACK_TIMEOUT);
    data = reg_rdata;
    @(negedge mclk);
    reg_cs = 1'b0;
  endtask

  task automatic set_timing();
    reg_data_t rd;
    reg_data_t tim;
    tim = reg_data_t'((TH1 << 20) | (TH0 << 10) | BIT_PER);
    bus_write(REG_TIM, tim, 4'hF);
    bus_write(REG_RST, reg_data_t'(RST_PER), 4'b0011);
    bus_read(REG_TIM, rd);
    check_equal("timing_readback", tim, rd);
  endtask

  // Pulse widths and spacing of a two-pixel burst
  task automatic measure_line(input int port, input logic [47:0] bits);
    int i;
    int high_cnt;
    int period_cnt;
    int wait_cnt;
    wait_cnt = 0;
    while (!led_dout[port]) begin
      wait_cnt++;
      if (wait_cnt > START_TIMEOUT)
        abort_run("No pulse on the LED line after the pixel push");
      else
        @(negedge mclk);
    end
    for (i = 0; i < 48; i++) begin
      high_cnt   = 0;
      period_cnt = 0;
      while (led_dout[port]) begin
        high_cnt++;
        period_cnt++;
        if (high_cnt > BIT_PER)
          abort_run("LED line stuck high");
        else
          @(negedge mclk);
      end
      // MSB of the first pixel goes first
      check_equal($sformatf("bit%0d_high", i), bits[47-i] ? TH1 : TH0, high_cnt);
      if (i < 47) begin
        while (!led_dout[port]) begin
          period_cnt++;
          if (period_cnt > 2 * BIT_PER)
            abort_run("Gap between bits on the LED line");
          else
            @(negedge mclk);
        end
        check_equal($sformatf("bit%0d_spacing", i), BIT_PER, period_cnt);
      end
    end
  endtask

  // Low cycles from the current negedge up to the next rising edge
  task automatic measure_low(input int port, input int expected);
    int low_cnt;
    low_cnt = 0;
    while (!led_dout[port]) begin
      low_cnt++;
      if (low_cnt > expected + START_TIMEOUT)
        abort_run("No pulse on the LED line after the latch");
      else
        @(negedge mclk);
    end
    check_equal("latch_low", expected, low_cnt);
  endtask

  // --------------------------------------
  // Directed tests
  // --------------------------------------
  task automatic test_reset_and_config();
    reg_data_t rd;
    reg_data_t tim_exp;
    reg_data_t rst_exp;
    bus_read(REG_STS, rd);
    check_equal("reset_status", 32'h0202_0202, rd);
    check_equal("reset_lines", 32'd0, 32'(led_dout));
    bus_read(REG_ENB, rd);
    check_equal("reset_enable", 32'd0, rd);
    bus_read(REG_TIM, rd);
    check_equal("reset_timing", 32'd0, rd);
    tim_exp = '0;
    // Timing register, alternating byte lanes
    bus_write(REG_TIM, 32'hDEAD_BEEF, 4'b0101);
    tim_exp = byte_merge(tim_exp, 32'hDEAD_BEEF, 4'b0101) & TIM_MASK;
    bus_read(REG_TIM, rd);
    check_equal("tim_be_0101", tim_exp, rd);
    bus_write(REG_TIM, 32'hF0E1_D2C3, 4'b1010);
    tim_exp = byte_merge(tim_exp, 32'hF0E1_D2C3, 4'b1010) & TIM_MASK;
    bus_read(REG_TIM, rd);
    check_equal("tim_be_1010", tim_exp, rd);
    // Reset period, upper lanes have no storage
    rst_exp = '0;
    bus_write(REG_RST, 32'h1234_5678, 4'b0010);
    rst_exp = byte_merge(rst_exp, 32'h1234_5678, 4'b0010) & RST_MASK;
    bus_read(REG_RST, rd);
    check_equal("rst_be_0010", rst_exp, rd);
    bus_write(REG_RST, 32'hAAAA_55CC, 4'b1101);
    rst_exp = byte_merge(rst_exp, 32'hAAAA_55CC, 4'b1101) & RST_MASK;
    bus_read(REG_RST, rd);
    check_equal("rst_be_1101", rst_exp, rd);
  endtask

  task automatic test_fill_port0();
    reg_data_t rd;
    int        i;
    bus_write(REG_ENB, 32'd0, 4'b0001);
    for (i = 0; i < FIFO_DEPTH; i++) begin
      next_pixel(port0_pix[i]);
      bus_write(REG_DATA0, 32'(port0_pix[i]), 4'hF);
    end
    // Port 0 full, others empty
    bus_read(REG_STS, rd);
    check_equal("fill_status", 32'h0202_0201, rd);
    bus_read(REG_DATA0, rd);
    check_equal("fill_head", 32'(port0_pix[0]), rd);
  endtask

  task automatic test_back_pressure();
    reg_data_t rd;
    pixel_t    extra;
    int        c;
    next_pixel(extra);
    reg_cs    = 1'b1;
    reg_wr    = 1'b1;
    reg_addr  = REG_DATA0;
    reg_wdata = 32'(extra);
    reg_be    = 4'hF;
    for (c = 0; c < 50; c++) begin
      @(negedge mclk);
      if (reg_ack)
        abort_run("Write to a full FIFO was acknowledged");
    end
    // Withdraw the stalled access, nothing pushed without an ack
    reg_cs = 1'b0;
    reg_wr = 1'b0;
    @(negedge mclk);
    set_timing();
    bus_write(REG_ENB, 32'h0000_0001, 4'b0001);
    // Serializer pop frees one slot for the ninth word
    bus_write(REG_DATA0, 32'(extra), 4'hF, PIXEL_TIMEOUT);
    bus_read(REG_STS, rd);
    check_equal("refill_status", 32'h0202_0201, rd);
    bus_read(REG_DATA0, rd);
    check_equal("head_after_pop", 32'(port0_pix[1]), rd);
  endtask

  task automatic test_waveform_and_latch();
    reg_data_t rd;
    pixel_t    pix_a;
    pixel_t    pix_b;
    pixel_t    pix_c;
    int        tail;
    set_timing();
    // Port 0 keeps draining, ports 1 to 3 on
    bus_write(REG_ENB, 32'h0000_000F, 4'b0001);
    next_pixel(pix_a);
    next_pixel(pix_b);
    next_pixel(pix_c);
    fork
      begin
        bus_write(reg_addr_t'(REG_DATA0 + 1), 32'(pix_a), 4'hF);
        bus_write(reg_addr_t'(REG_DATA0 + 1), 32'(pix_b), 4'hF);
      end
      measure_line(1, {pix_a, pix_b});
    join
    // Low rest of the last bit
    tail = BIT_PER - (pix_b[0] ? TH1 : TH0);
    fork
      begin
        // Third pixel arrives inside the latch and waits for its end
        repeat (tail) @(negedge mclk);
        bus_write(reg_addr_t'(REG_DATA0 + 1), 32'(pix_c), 4'hF);
      end
      // Bit tail, latch, then one idle cycle before the next first bit
      measure_low(1, tail + RST_PER + 1);
    join
    // Port 1 drained, ports 2 and 3 never filled
    bus_read(REG_STS, rd);
    check_equal("latch_status", 32'h0002_0202, 32'(rd[31:8]));
  endtask

  // --------------------------------------
  // Main sequence
  // --------------------------------------
  initial begin
    h_reset_n  = 1'b0;
    reg_cs     = 1'b0;
    reg_wr     = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    reg_be     = '0;
    watch_idle = 1'b0;
    lfsr_state = 16'd41384;
    repeat (2) @(negedge mclk);
    h_reset_n = 1'b1;
    @(negedge mclk);
    watch_idle = 1'b1;
    test_reset_and_config();
    test_fill_port0();
    test_back_pressure();
    test_waveform_and_latch();
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

/* ws281x.f */
source/ws281x_pkg.sv
source/ws281x_fifo.sv
source/ws281x_reg.sv
source/ws281x_serializer.sv
source/ws281x_top.sv
test/ws281x_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the ws281x testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f ws281x.f --top-module ws281x_tb -o sim_ws281x
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/sim_ws281x
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit "$status"
fi

exit 0
